// File: common/hbm_traffic_pkg.sv
package hbm_traffic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // AXI port geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int addr_w = 33;         // HBM pseudo channel address space
    localparam int data_w = 256;
    localparam int strb_w = data_w / 8;
    localparam int len_w  = 4;          // AXI3 style burst length field

    ////////////////////////////////////////////////////////////////////////////
    // Fixed burst attributes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] size_32b   = 3'd5;   // log2 of bytes per beat

    // 16 beats of 32 bytes per burst
    localparam logic [addr_w-1:0] burst_step = 33'h200;

    // Replicated across the whole data bus
    localparam logic [31:0] data_pattern = 32'ha5a5a5a5;

    ////////////////////////////////////////////////////////////////////////////
    // Operating mode
    ////////////////////////////////////////////////////////////////////////////

    // Encodings follow the shared read_or_write CSR
    // Anything not listed leaves the port idle
    typedef enum logic [2:0] {
        mode_read       = 3'd3,     // Queued reads
        mode_write      = 3'd4,     // Queued writes
        mode_read_write = 3'd5      // Both queues together
    } traffic_mode_t;

endpackage

// File: verilog/burst_addr_gen.sv
`timescale 1ns/10ps

module burst_addr_gen #(
    parameter int unsigned gen_num = 0,
    parameter logic [hbm_traffic_pkg::addr_w-1:0] addr_span = 33'h1000_0000
) (
    input  logic                                axi_aclk,
    input  logic                                axi_aresetn,
    input  logic                                addr_inc_en,
    input  logic                                addr_advance,
    output logic [hbm_traffic_pkg::addr_w-1:0]  addr
);

    localparam int aw = hbm_traffic_pkg::addr_w;

    localparam logic [aw-1:0] gen_idx     = {{(aw - 32){1'b0}}, gen_num};
    localparam logic [aw-1:0] base_addr   = gen_idx * addr_span;   // Window start
    localparam logic [aw-1:0] wrap_margin = 'h400;
    // Highest address that may still step forward
    localparam logic [aw-1:0] last_step   = base_addr + addr_span - wrap_margin;

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            addr <= base_addr;
        end
        else if (!addr_inc_en)
        begin
            addr <= base_addr;      // Fixed address mode
        end
        else if (addr_advance)
        begin
            if (addr <= last_step)
                addr <= addr + hbm_traffic_pkg::burst_step;
            else
                addr <= base_addr;  // Wrap to window start
        end
    end

    // Offset from base wraps huge if the address ever drops below it
    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (addr - base_addr) < addr_span);

endmodule

// File: traffic_gen/read_engine.sv
`timescale 1ns/10ps

module read_engine #(
    parameter int unsigned gen_num         = 0,
    parameter int unsigned max_outstanding = 61
) (
    input  logic                                axi_aclk,
    input  logic                                axi_aresetn,
    input  logic                                start,
    input  hbm_traffic_pkg::traffic_mode_t      mode,
    input  logic [31:0]                         port_mask,
    input  logic [hbm_traffic_pkg::addr_w-1:0]  addr,
    output logic                                addr_advance,

    // AR channel
    output logic                                arvalid,
    input  logic                                arready,

    // R channel
    input  logic                                rvalid,
    input  logic                                rlast,
    output logic                                rready
);

    localparam int cnt_w = $clog2(max_outstanding + 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(max_outstanding);

    logic               enable;
    logic               ar_hs;
    logic               r_done;
    logic [cnt_w-1:0]   rd_count;   // Bursts issued and not yet drained

    assign enable = port_mask[gen_num] &&
                    (mode == hbm_traffic_pkg::mode_read ||
                     mode == hbm_traffic_pkg::mode_read_write);

    ////////////////////////////////////////////////////////////////////////////
    // Address issue
    ////////////////////////////////////////////////////////////////////////////

    // New AR may go out the cycle after a handshake
    assign arvalid      = enable && start && (rd_count < cnt_max);
    assign ar_hs        = arvalid && arready;
    assign addr_advance = ar_hs;

    ////////////////////////////////////////////////////////////////////////////
    // Read data drain
    ////////////////////////////////////////////////////////////////////////////

    // Keep draining after start or the enable goes away
    assign rready = enable || (rd_count != '0);
    assign r_done = rvalid && rready && rlast;  // One burst finished

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            rd_count <= '0;
        end
        else if (ar_hs && !r_done)
        begin
            rd_count <= rd_count + 1'b1;
        end
        else if (!ar_hs && r_done)
        begin
            rd_count <= rd_count - 1'b1;
        end
    end

    // Limit holds and every rlast belongs to an issued burst
    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (rd_count <= cnt_max) && !(r_done && rd_count == '0));

    // Address held by the generator while AR waits
    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (arvalid && !arready) |=> $stable(addr));

endmodule

// File: traffic_gen/write_engine.sv
`timescale 1ns/10ps

module write_engine #(
    parameter int unsigned gen_num         = 0,
    parameter int unsigned max_outstanding = 61
) (
    input  logic                                axi_aclk,
    input  logic                                axi_aresetn,
    input  logic                                start,
    input  hbm_traffic_pkg::traffic_mode_t      mode,
    input  logic [31:0]                         port_mask,
    input  logic [hbm_traffic_pkg::len_w-1:0]   burst_len,
    input  logic [hbm_traffic_pkg::addr_w-1:0]  addr,
    output logic                                addr_advance,

    // AW channel
    output logic                                awvalid,
    input  logic                                awready,

    // W channel
    output logic                                wvalid,
    input  logic                                wready,
    output logic                                wlast,

    // B channel
    input  logic                                bvalid,
    output logic                                bready
);

    localparam int cnt_w = $clog2(max_outstanding + 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(max_outstanding);

    logic                                   enable;
    logic                                   aw_hs;
    logic                                   w_hs;
    logic                                   w_last_hs;
    logic                                   b_hs;
    logic [cnt_w-1:0]                       wr_count;   // Awaiting a B response
    logic [cnt_w-1:0]                       owed;       // Accepted AW with data unsent
    logic [hbm_traffic_pkg::len_w-1:0]      beat_cnt;

    assign enable = port_mask[gen_num] &&
                    (mode == hbm_traffic_pkg::mode_write ||
                     mode == hbm_traffic_pkg::mode_read_write);

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////////////////////

    assign awvalid      = enable && start && (wr_count < cnt_max);
    assign aw_hs        = awvalid && awready;
    assign addr_advance = aw_hs;

    assign wvalid    = (owed != '0);
    assign wlast     = wvalid && (beat_cnt == burst_len);
    assign w_hs      = wvalid && wready;
    assign w_last_hs = w_hs && wlast;

    assign bready = (wr_count != '0);
    assign b_hs   = bvalid && bready;

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            wr_count <= '0;
            owed     <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            case ({aw_hs, b_hs})
                2'b10:   wr_count <= wr_count + 1'b1;
                2'b01:   wr_count <= wr_count - 1'b1;
                default: wr_count <= wr_count;
            endcase

            // A burst stops being owed once its last beat is taken
            case ({aw_hs, w_last_hs})
                2'b10:   owed <= owed + 1'b1;
                2'b01:   owed <= owed - 1'b1;
                default: owed <= owed;
            endcase

            if (w_hs)
                beat_cnt <= wlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // Stalled beat keeps its position and last flag
    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (wvalid && !wready) |=> wvalid && $stable(beat_cnt) && $stable(wlast));

    // Data owed never exceeds writes in flight, B only after wlast
    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (owed <= wr_count) && (wr_count <= cnt_max));

    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (awvalid && !awready) |=> $stable(addr));

endmodule

// File: traffic_gen/traffic_gen.sv
`timescale 1ns/10ps

module traffic_gen #(
    parameter int unsigned gen_num = 0,
    parameter logic [hbm_traffic_pkg::addr_w-1:0] addr_span = 33'h1000_0000,
    parameter int unsigned max_outstanding = 61
) (
    input  logic                                axi_aclk,
    input  logic                                axi_aresetn,

    // Shared control
    input  logic                                csr_start,
    input  logic [2:0]                          read_or_write,
    input  logic                                address_inc_csr,
    input  logic [31:0]                         port_mask,
    input  logic [hbm_traffic_pkg::len_w-1:0]   transaction_length,

    // AW
    output logic [hbm_traffic_pkg::addr_w-1:0]  axi_awaddr,
    output logic [1:0]                          axi_awburst,
    output logic [hbm_traffic_pkg::len_w-1:0]   axi_awlen,
    output logic [2:0]                          axi_awsize,
    output logic                                axi_awvalid,
    input  logic                                axi_awready,

    // W
    output logic [hbm_traffic_pkg::data_w-1:0]  axi_wdata,
    output logic [hbm_traffic_pkg::strb_w-1:0]  axi_wstrb,
    output logic                                axi_wlast,
    output logic                                axi_wvalid,
    input  logic                                axi_wready,

    // B
    input  logic                                axi_bvalid,
    output logic                                axi_bready,

    // AR
    output logic [hbm_traffic_pkg::addr_w-1:0]  axi_araddr,
    output logic [1:0]                          axi_arburst,
    output logic [hbm_traffic_pkg::len_w-1:0]   axi_arlen,
    output logic [2:0]                          axi_arsize,
    output logic                                axi_arvalid,
    input  logic                                axi_arready,

    // R
    input  logic                                axi_rvalid,
    input  logic                                axi_rlast,
    output logic                                axi_rready
);

    hbm_traffic_pkg::traffic_mode_t mode;
    logic                           rd_advance;
    logic                           wr_advance;

    assign mode = hbm_traffic_pkg::traffic_mode_t'(read_or_write);

    // Fixed burst shape, INCR of full width beats
    assign axi_arburst = hbm_traffic_pkg::burst_incr;
    assign axi_awburst = hbm_traffic_pkg::burst_incr;
    assign axi_arsize  = hbm_traffic_pkg::size_32b;
    assign axi_awsize  = hbm_traffic_pkg::size_32b;
    assign axi_arlen   = transaction_length;
    assign axi_awlen   = transaction_length;
    assign axi_wdata   = {(hbm_traffic_pkg::data_w / 32){hbm_traffic_pkg::data_pattern}};
    assign axi_wstrb   = '1;    // Full beats only

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    burst_addr_gen #(.gen_num(gen_num), .addr_span(addr_span)) u_rd_addr (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .addr_inc_en  (address_inc_csr),
        .addr_advance (rd_advance),
        .addr         (axi_araddr)
    );

    read_engine #(.gen_num(gen_num), .max_outstanding(max_outstanding)) u_rd_eng (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .start        (csr_start),
        .mode         (mode),
        .port_mask    (port_mask),
        .addr         (axi_araddr),
        .addr_advance (rd_advance),
        .arvalid      (axi_arvalid),
        .arready      (axi_arready),
        .rvalid       (axi_rvalid),
        .rlast        (axi_rlast),
        .rready       (axi_rready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    burst_addr_gen #(.gen_num(gen_num), .addr_span(addr_span)) u_wr_addr (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .addr_inc_en  (address_inc_csr),
        .addr_advance (wr_advance),
        .addr         (axi_awaddr)
    );

    write_engine #(.gen_num(gen_num), .max_outstanding(max_outstanding)) u_wr_eng (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .start        (csr_start),
        .mode         (mode),
        .port_mask    (port_mask),
        .burst_len    (transaction_length),
        .addr         (axi_awaddr),
        .addr_advance (wr_advance),
        .awvalid      (axi_awvalid),
        .awready      (axi_awready),
        .wvalid       (axi_wvalid),
        .wready       (axi_wready),
        .wlast        (axi_wlast),
        .bvalid       (axi_bvalid),
        .bready       (axi_bready)
    );

endmodule

// File: verif/axi_slave_model.sv
`timescale 1ns/10ps

module axi_slave_model (
    input  logic        axi_aclk,
    input  logic        axi_aresetn,
    input  logic [3:0]  burst_len,
    input  logic        slow,           // Push response delays toward the top of the range
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    output logic        rlast,
    input  logic        rready,
    output logic        awready,
    input  logic        wvalid,
    input  logic        wlast,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);

    logic           active;
    logic [3:0]     beat;           // Position inside the current R burst
    int unsigned    cycle;
    int unsigned    r_due[$];       // Cycle from which each read burst may return
    int unsigned    b_due[$];

    function automatic int unsigned resp_delay();
        return slow ? $urandom_range(12, 8) : $urandom_range(12, 1);
    endfunction

    initial
    begin
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        bvalid  = 1'b0;
        active  = 1'b0;
        beat    = '0;
        cycle   = 0;
        forever
        begin
            @(posedge axi_aclk);
            active = axi_aresetn;
            if (!active)
            begin
                cycle = 0;
                beat  = '0;
                r_due.delete();
                b_due.delete();
            end
            else
            begin
                cycle++;
                if (arvalid && arready)
                    r_due.push_back(cycle + resp_delay());
                // Response only once the whole write burst is in
                if (wvalid && wready && wlast)
                    b_due.push_back(cycle + resp_delay());
                if (rvalid && rready)
                begin
                    if (rlast)
                    begin
                        r_due.delete(0);
                        beat = '0;
                    end
                    else
                    begin
                        beat = beat + 4'd1;
                    end
                end
                if (bvalid && bready)
                    b_due.delete(0);
            end

            #1;     // Drive away from the edge
            arready = active && ($urandom_range(3, 0) != 0);
            awready = active && ($urandom_range(3, 0) != 0);
            wready  = active && ($urandom_range(3, 0) != 0);
            rvalid  = (r_due.size() != 0) && (r_due[0] <= cycle);
            rlast   = rvalid && (beat == burst_len);   // Burst length plus one beats
            bvalid  = (b_due.size() != 0) && (b_due[0] <= cycle);
        end
    end

endmodule

// File: verif/tb_traffic_gen.sv
`timescale 1ns/10ps

module tb_traffic_gen;

    localparam int clk_period   = 4;
    localparam int max_out      = 4;
    localparam int phase_cycles = 1000;         // Budget for any single wait
    // Six phases, each a run and a drain, plus margin
    localparam int watchdog_ns  = 6 * 2 * phase_cycles * clk_period + 20000;

    localparam int aw = hbm_traffic_pkg::addr_w;
    localparam logic [aw-1:0] base      = 33'h2000;     // Generator 2 of a 0x1000 window
    localparam logic [255:0]  exp_wdata = {8{32'ha5a5_a5a5}};

    logic               axi_aclk = 1'b0;
    logic               axi_aresetn;
    logic               csr_start;
    logic [2:0]         read_or_write;
    logic               address_inc_csr;
    logic [31:0]        port_mask;
    logic [3:0]         transaction_length;
    logic               slow_resp;

    logic [aw-1:0]      axi_awaddr;
    logic [aw-1:0]      axi_araddr;
    logic [1:0]         axi_awburst;
    logic [1:0]         axi_arburst;
    logic [3:0]         axi_awlen;
    logic [3:0]         axi_arlen;
    logic [2:0]         axi_awsize;
    logic [2:0]         axi_arsize;
    logic [255:0]       axi_wdata;
    logic [31:0]        axi_wstrb;
    logic               axi_awvalid;
    logic               axi_awready;
    logic               axi_wvalid;
    logic               axi_wready;
    logic               axi_wlast;
    logic               axi_bvalid;
    logic               axi_bready;
    logic               axi_arvalid;
    logic               axi_arready;
    logic               axi_rvalid;
    logic               axi_rlast;
    logic               axi_rready;

    string              test_name = "reset";
    int                 errors = 0;
    logic               masked;
    logic               stopped;        // Start has been dropped
    int                 ar_total;
    int                 aw_total;
    int                 wlast_total;
    int                 rd_out;
    int                 wr_out;
    int                 rd_peak;
    int                 wr_peak;
    logic [3:0]         w_beat;
    logic [2:0]         rd_slot;        // Eight 0x200 bursts fill the 0x1000 window
    logic [2:0]         wr_slot;

    wire ar_hs     = axi_arvalid && axi_arready;
    wire aw_hs     = axi_awvalid && axi_awready;
    wire w_hs      = axi_wvalid && axi_wready;
    wire r_last_hs = axi_rvalid && axi_rready && axi_rlast;
    wire b_hs      = axi_bvalid && axi_bready;

    always #(clk_period / 2) axi_aclk = ~axi_aclk;

    traffic_gen #(
        .gen_num         (2),
        .addr_span       (33'h1000),
        .max_outstanding (max_out)
    ) u_dut (
        .axi_aclk           (axi_aclk),
        .axi_aresetn        (axi_aresetn),
        .csr_start          (csr_start),
        .read_or_write      (read_or_write),
        .address_inc_csr    (address_inc_csr),
        .port_mask          (port_mask),
        .transaction_length (transaction_length),
        .axi_awaddr         (axi_awaddr),
        .axi_awburst        (axi_awburst),
        .axi_awlen          (axi_awlen),
        .axi_awsize         (axi_awsize),
        .axi_awvalid        (axi_awvalid),
        .axi_awready        (axi_awready),
        .axi_wdata          (axi_wdata),
        .axi_wstrb          (axi_wstrb),
        .axi_wlast          (axi_wlast),
        .axi_wvalid         (axi_wvalid),
        .axi_wready         (axi_wready),
        .axi_bvalid         (axi_bvalid),
        .axi_bready         (axi_bready),
        .axi_araddr         (axi_araddr),
        .axi_arburst        (axi_arburst),
        .axi_arlen          (axi_arlen),
        .axi_arsize         (axi_arsize),
        .axi_arvalid        (axi_arvalid),
        .axi_arready        (axi_arready),
        .axi_rvalid         (axi_rvalid),
        .axi_rlast          (axi_rlast),
        .axi_rready         (axi_rready)
    );

    axi_slave_model u_slave (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .burst_len   (transaction_length),
        .slow        (slow_resp),
        .arvalid     (axi_arvalid),
        .arready     (axi_arready),
        .rvalid      (axi_rvalid),
        .rlast       (axi_rlast),
        .rready      (axi_rready),
        .awready     (axi_awready),
        .wvalid      (axi_wvalid),
        .wlast       (axi_wlast),
        .wready      (axi_wready),
        .bvalid      (axi_bvalid),
        .bready      (axi_bready)
    );

    task automatic log_mismatch(input string what, input logic [255:0] exp,
                                input logic [255:0] act);
        errors++;
        $display("MISMATCH [%s] %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic count_failure(input string msg);
        errors++;
        $display("ERROR [%s] %s at %0t", test_name, msg, $time);
    endtask

    // Burst address of a slot inside the window
    function automatic logic [aw-1:0] slot_addr(input logic [2:0] slot);
        return base + aw'(slot) * 33'h200;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and per-beat checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            ar_total    <= 0;
            aw_total    <= 0;
            wlast_total <= 0;
            rd_out      <= 0;
            wr_out      <= 0;
            rd_peak     <= 0;
            wr_peak     <= 0;
            w_beat      <= '0;
            rd_slot     <= '0;
            wr_slot     <= '0;
        end
        else
        begin
            if (ar_hs)
            begin
                assert (axi_araddr == slot_addr(rd_slot))
                    else log_mismatch("araddr", 256'(slot_addr(rd_slot)), 256'(axi_araddr));
                // Length, INCR, 32-byte beats
                assert (axi_arlen == transaction_length && axi_arburst == 2'b01 &&
                        axi_arsize == 3'd5)
                    else log_mismatch("ar shape", 256'({transaction_length, 2'b01, 3'd5}),
                                      256'({axi_arlen, axi_arburst, axi_arsize}));
            end
            if (aw_hs)
            begin
                assert (axi_awaddr == slot_addr(wr_slot))
                    else log_mismatch("awaddr", 256'(slot_addr(wr_slot)), 256'(axi_awaddr));
                assert (axi_awlen == transaction_length && axi_awburst == 2'b01 &&
                        axi_awsize == 3'd5)
                    else log_mismatch("aw shape", 256'({transaction_length, 2'b01, 3'd5}),
                                      256'({axi_awlen, axi_awburst, axi_awsize}));
            end
            if (w_hs)
            begin
                assert (axi_wdata == exp_wdata)
                    else log_mismatch("wdata", exp_wdata, axi_wdata);
                assert (axi_wstrb == 32'hffff_ffff)
                    else log_mismatch("wstrb", 256'(32'hffff_ffff), 256'(axi_wstrb));
                assert (axi_wlast == (w_beat == transaction_length))
                    else log_mismatch("wlast", 256'(w_beat == transaction_length),
                                      256'(axi_wlast));
                w_beat <= (w_beat == transaction_length) ? 4'd0 : w_beat + 4'd1;
            end
            rd_slot     <= !address_inc_csr ? 3'd0 : rd_slot + 3'(ar_hs);
            wr_slot     <= !address_inc_csr ? 3'd0 : wr_slot + 3'(aw_hs);
            ar_total    <= ar_total + int'(ar_hs);
            aw_total    <= aw_total + int'(aw_hs);
            wlast_total <= wlast_total + int'(w_hs && axi_wlast);
            rd_out      <= rd_out + int'(ar_hs) - int'(r_last_hs);
            wr_out      <= wr_out + int'(aw_hs) - int'(b_hs);
            rd_peak     <= (rd_out > rd_peak) ? rd_out : rd_peak;
            wr_peak     <= (wr_out > wr_peak) ? wr_out : wr_peak;
        end
    end

    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        rd_out <= max_out && wr_out <= max_out)
        else count_failure("more bursts in flight than the outstanding limit");

    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        masked |-> !(axi_arvalid || axi_awvalid || axi_wvalid))
        else count_failure("valid raised while the port is masked off");

    assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        stopped |-> !(ar_hs || aw_hs))
        else count_failure("address handshake after start fell");

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic step_cycle();
        @(posedge axi_aclk);
        #1;
    endtask

    // Settings change with start low, then start rises a cycle later
    task automatic begin_phase(input string name, input hbm_traffic_pkg::traffic_mode_t mode,
                               input logic inc, input logic [3:0] len, input logic slow);
        test_name          = name;
        read_or_write      = mode;
        address_inc_csr    = inc;
        transaction_length = len;
        slow_resp          = slow;
        step_cycle();
        stopped   = 1'b0;
        csr_start = 1'b1;
    endtask

    task automatic wait_for_bursts(input int ar_n, input int aw_n);
        int ar_goal;
        int aw_goal;
        int waited;
        ar_goal = ar_total + ar_n;
        aw_goal = aw_total + aw_n;
        waited  = 0;
        while ((ar_total < ar_goal || aw_total < aw_goal) && waited < phase_cycles)
        begin
            step_cycle();
            waited++;
        end
        if (ar_total < ar_goal || aw_total < aw_goal)
            count_failure("timed out waiting for address handshakes");
    endtask

    task automatic drain_traffic();
        int waited;
        csr_start = 1'b0;
        stopped   = 1'b1;
        waited    = 0;
        while ((rd_out != 0 || wr_out != 0) && waited < phase_cycles)
        begin
            step_cycle();
            waited++;
        end
        if (rd_out != 0 || wr_out != 0)
            count_failure("bursts still outstanding after start fell");
        assert (wlast_total == aw_total)
            else log_mismatch("w bursts", 256'(aw_total), 256'(wlast_total));
        read_or_write = 3'd0;   // Idle, so ready only reflects the DUT counts
        step_cycle();
        assert (!axi_rready && !axi_bready)
            else count_failure("ready still high with nothing outstanding");
    endtask

    initial
    begin
        void'($urandom(28));
        axi_aresetn        = 1'b0;
        csr_start          = 1'b0;
        read_or_write      = 3'd0;
        address_inc_csr    = 1'b1;
        port_mask          = 32'h0000_0004;
        transaction_length = 4'd0;
        slow_resp          = 1'b0;
        masked             = 1'b0;
        stopped            = 1'b0;
        repeat (4) @(posedge axi_aclk);
        #1;
        axi_aresetn = 1'b1;

        begin_phase("read_sweep", hbm_traffic_pkg::mode_read, 1'b1, 4'd3, 1'b0);
        wait_for_bursts(12, 0);         // Past the wrap at 0x2E00
        drain_traffic();

        begin_phase("fixed_addr", hbm_traffic_pkg::mode_write, 1'b0, 4'd0, 1'b0);
        wait_for_bursts(0, 10);
        drain_traffic();

        begin_phase("write_data", hbm_traffic_pkg::mode_write, 1'b1, 4'd7, 1'b0);
        wait_for_bursts(0, 10);
        drain_traffic();

        begin_phase("outstanding_limit", hbm_traffic_pkg::mode_read_write, 1'b1, 4'd15, 1'b1);
        wait_for_bursts(12, 12);
        drain_traffic();
        assert (rd_peak == max_out)
            else log_mismatch("peak reads", 256'(max_out), 256'(rd_peak));
        assert (wr_peak == max_out)
            else log_mismatch("peak writes", 256'(max_out), 256'(wr_peak));

        port_mask = 32'hffff_fffb;      // Bit 2 clear
        masked    = 1'b1;
        begin_phase("port_masked", hbm_traffic_pkg::mode_read_write, 1'b1, 4'd3, 1'b0);
        repeat (200) step_cycle();
        drain_traffic();
        port_mask = 32'h0000_0004;
        masked    = 1'b0;

        begin_phase("start_drop", hbm_traffic_pkg::mode_read_write, 1'b1, 4'd3, 1'b0);
        wait_for_bursts(6, 6);
        drain_traffic();                // Drops start with bursts in flight

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, errors: %0d", watchdog_ns, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: filelist.f
common/hbm_traffic_pkg.sv
verilog/burst_addr_gen.sv
traffic_gen/read_engine.sv
traffic_gen/write_engine.sv
traffic_gen/traffic_gen.sv
verif/axi_slave_model.sv
verif/tb_traffic_gen.sv

// File: Makefile
TOP = tb_traffic_gen

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
